// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_digit_classifier -f compile.f -o tb_digit_classifier
	out="$$(./obj_dir/tb_digit_classifier)"; echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir

// File: compile.f
hdl/digit_pkg.sv
hdl/digit_templates.sv
hdl/digit_scorer.sv
hdl/score_argmax.sv
hdl/digit_apb_regs.sv
hdl/digit_classifier_top.sv
testbench/digit_classifier_asserts.sv
testbench/digit_checker.sv
testbench/tb_digit_classifier.sv

// File: hdl/digit_apb_regs.sv
`timescale 1ns/100ps

module digit_apb_regs
    import digit_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic [ADDR_W-1:0]  paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    input  logic [ROW_W-1:0]   row,
    output logic [IMG_DIM-1:0] img_row,
    output logic               start,
    input  logic               result_valid,
    input  logic [3:0]         digit
);

    logic [IMG_DIM-1:0] img_mem [IMG_DIM];
    logic               busy;
    logic               done;
    logic [3:0]         result_q;

    logic               access;
    logic               running;
    logic               hit_img;
    logic               hit_ctrl;
    logic               hit_status;
    logic               hit_result;
    logic               mapped;
    logic               wr_err;
    logic               start_req;
    logic               img_we;
    logic [ROW_W-1:0]   row_sel;

    assign access     = psel && penable;
    assign running    = busy || start;
    assign row_sel    = paddr[ROW_W+1:2];
    assign hit_img    = (paddr[1:0] == 2'b00) && (paddr < ADDR_W'(4 * IMG_DIM));
    assign hit_ctrl   = (paddr == ADDR_W'(REG_CTRL));
    assign hit_status = (paddr == ADDR_W'(REG_STATUS));
    assign hit_result = (paddr == ADDR_W'(REG_RESULT));
    assign mapped     = hit_img || hit_ctrl || hit_status || hit_result;

    // Image and start are locked from the start pulse until the result lands
    assign wr_err    = ((hit_img || hit_ctrl) && running) || hit_status || hit_result;
    assign pslverr   = access && (!mapped || (pwrite && wr_err));
    assign pready    = 1'b1;
    assign start_req = access && pwrite && hit_ctrl && pwdata[0] && !running;
    assign img_we    = access && pwrite && hit_img && !running;

    assign img_row = img_mem[row];

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (hit_img) begin
                prdata = 32'(img_mem[row_sel]);
            end else if (hit_status) begin
                prdata = {30'd0, done, busy};
            end else if (hit_result) begin
                prdata = {28'd0, result_q};
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (img_we) begin
            img_mem[row_sel] <= pwdata[IMG_DIM-1:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            start    <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            result_q <= '0;
        end else begin
            start <= start_req;
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (result_valid) begin
                busy     <= 1'b0;
                done     <= 1'b1;
                result_q <= digit;
            end
        end
    end

endmodule

// File: hdl/digit_classifier_top.sv
`timescale 1ns/100ps

module digit_classifier_top
    import digit_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic [ADDR_W-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr
);

    logic [ROW_W-1:0]                  row;
    logic [IMG_DIM-1:0]                img_row;
    logic [N_DIGITS-1:0][IMG_DIM-1:0]  mask_rows;
    logic [N_DIGITS-1:0][SCORE_W-1:0]  sons;
    logic [N_DIGITS-1:0][SCORE_W-1:0]  moms;
    logic                              start;
    logic                              scan_done;
    logic                              result_valid;
    logic [3:0]                        digit;

    digit_apb_regs #(
        .ADDR_W (ADDR_W)
    ) u_regs (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .row          (row),
        .img_row      (img_row),
        .start        (start),
        .result_valid (result_valid),
        .digit        (digit)
    );

    digit_templates u_templates (
        .row       (row),
        .mask_rows (mask_rows)
    );

    digit_scorer u_scorer (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .start     (start),
        .img_row   (img_row),
        .mask_rows (mask_rows),
        .row       (row),
        .sons      (sons),
        .moms      (moms),
        .scan_done (scan_done)
    );

    score_argmax u_argmax (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .scan_done    (scan_done),
        .sons         (sons),
        .moms         (moms),
        .digit        (digit),
        .result_valid (result_valid)
    );

endmodule

// File: hdl/digit_pkg.sv
package digit_pkg;

    localparam int IMG_DIM  = 30;
    localparam int N_DIGITS = 10;
    localparam int SCORE_W  = 12;
    localparam int ROW_W    = 5;
    localparam int N_SEGS   = 7;

    // Bit 0 is segment a, bit 6 is segment g
    localparam logic [N_SEGS-1:0] SEG_CODE [N_DIGITS] = '{
        7'b0111111,
        7'b0000110,
        7'b1011011,
        7'b1001111,
        7'b1100110,
        7'b1101101,
        7'b1111101,
        7'b0000111,
        7'b1111111,
        7'b1101111
    };

    // Inclusive rectangle of each segment, a to g
    localparam int SEG_ROW_LO [N_SEGS] = '{2, 2, 14, 25, 14, 2, 14};
    localparam int SEG_ROW_HI [N_SEGS] = '{4, 15, 27, 27, 27, 15, 16};
    localparam int SEG_COL_LO [N_SEGS] = '{6, 21, 21, 6, 6, 6, 6};
    localparam int SEG_COL_HI [N_SEGS] = '{23, 23, 23, 23, 8, 8, 23};

    localparam logic [7:0] REG_CTRL   = 8'h80;
    localparam logic [7:0] REG_STATUS = 8'h84;
    localparam logic [7:0] REG_RESULT = 8'h88;

endpackage

// File: hdl/digit_scorer.sv
`timescale 1ns/100ps

module digit_scorer
    import digit_pkg::*;
(
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              start,
    input  logic [IMG_DIM-1:0]                img_row,
    input  logic [N_DIGITS-1:0][IMG_DIM-1:0]  mask_rows,
    output logic [ROW_W-1:0]                  row,
    output logic [N_DIGITS-1:0][SCORE_W-1:0]  sons,
    output logic [N_DIGITS-1:0][SCORE_W-1:0]  moms,
    output logic                              scan_done
);

    typedef enum logic {
        S_IDLE,
        S_SCAN
    } state_t;

    localparam logic [ROW_W-1:0] LAST = ROW_W'(IMG_DIM - 1);

    state_t                            state;
    logic [ROW_W-1:0]                  col;
    logic                              pix;
    logic                              step;
    logic                              fresh;
    logic                              last_pix;
    logic [N_DIGITS-1:0][SCORE_W-1:0]  son_next;
    logic [N_DIGITS-1:0][SCORE_W-1:0]  mom_next;

    // Pixel (0,0) is scored in the start cycle itself
    assign fresh    = (state == S_IDLE);
    assign step     = (state == S_SCAN) || (fresh && start);
    assign last_pix = (state == S_SCAN) && (col == LAST) && (row == LAST);
    assign pix      = img_row[col];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= S_IDLE;
            row       <= '0;
            col       <= '0;
            scan_done <= 1'b0;
        end else begin
            scan_done <= last_pix;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_SCAN;
                        col   <= ROW_W'(1);
                    end
                end
                S_SCAN: begin
                    if (col == LAST) begin
                        col <= '0;
                        if (row == LAST) begin
                            row   <= '0;
                            state <= S_IDLE;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Hit adds 2 to both counts, a mismatch adds 1 to mom only
    always_comb begin
        logic hit;
        logic miss;
        for (int d = 0; d < N_DIGITS; d++) begin
            hit         = pix & mask_rows[d][col];
            miss        = pix ^ mask_rows[d][col];
            son_next[d] = (fresh ? '0 : sons[d]) + SCORE_W'({hit, 1'b0});
            mom_next[d] = (fresh ? '0 : moms[d]) + SCORE_W'({hit, miss});
        end
    end

    always_ff @(posedge i_clk) begin
        if (step) begin
            sons <= son_next;
            moms <= mom_next;
        end
    end

endmodule

// File: hdl/digit_templates.sv
`timescale 1ns/100ps

module digit_templates
    import digit_pkg::*;
(
    input  logic [ROW_W-1:0]                 row,
    output logic [N_DIGITS-1:0][IMG_DIM-1:0] mask_rows
);

    logic [N_SEGS-1:0][IMG_DIM-1:0] seg_map;

    // Columns covered by each segment on the current row
    always_comb begin
        for (int s = 0; s < N_SEGS; s++) begin
            for (int c = 0; c < IMG_DIM; c++) begin
                seg_map[s][c] = (int'(row) >= SEG_ROW_LO[s]) &&
                                (int'(row) <= SEG_ROW_HI[s]) &&
                                (c >= SEG_COL_LO[s]) &&
                                (c <= SEG_COL_HI[s]);
            end
        end
    end

    always_comb begin
        mask_rows = '0;
        for (int d = 0; d < N_DIGITS; d++) begin
            for (int s = 0; s < N_SEGS; s++) begin
                if (SEG_CODE[d][s]) begin
                    mask_rows[d] = mask_rows[d] | seg_map[s];
                end
            end
        end
    end

endmodule

// File: hdl/score_argmax.sv
`timescale 1ns/100ps

module score_argmax
    import digit_pkg::*;
(
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              scan_done,
    input  logic [N_DIGITS-1:0][SCORE_W-1:0]  sons,
    input  logic [N_DIGITS-1:0][SCORE_W-1:0]  moms,
    output logic [3:0]                        digit,
    output logic                              result_valid
);

    localparam int N_NODES = 2 * N_DIGITS - 1;
    localparam int N_CMP   = N_DIGITS - 1;

    // Knockout pairing; node N_DIGITS+k is the winner of comparison k
    localparam int LEFT  [N_CMP] = '{0, 2, 4, 6, 8, 10, 12, 15, 14};
    localparam int RIGHT [N_CMP] = '{1, 3, 5, 7, 9, 11, 13, 16, 17};

    logic [3:0] best_idx;

    function automatic logic a_wins(
        input logic [SCORE_W-1:0] son_a,
        input logic [SCORE_W-1:0] mom_a,
        input logic [3:0]         idx_a,
        input logic [SCORE_W-1:0] son_b,
        input logic [SCORE_W-1:0] mom_b,
        input logic [3:0]         idx_b
    );
        logic [2*SCORE_W-1:0] lhs;
        logic [2*SCORE_W-1:0] rhs;
        lhs = (2*SCORE_W)'(son_a) * (2*SCORE_W)'(mom_b);
        rhs = (2*SCORE_W)'(son_b) * (2*SCORE_W)'(mom_a);
        return (lhs > rhs) || ((lhs == rhs) && (idx_a < idx_b));
    endfunction

    always_comb begin
        logic [3:0]         n_idx [N_NODES];
        logic [SCORE_W-1:0] n_son [N_NODES];
        logic [SCORE_W-1:0] n_mom [N_NODES];
        for (int i = 0; i < N_DIGITS; i++) begin
            n_idx[i] = 4'(i);
            n_son[i] = sons[i];
            n_mom[i] = moms[i];
        end
        for (int k = 0; k < N_CMP; k++) begin
            if (a_wins(n_son[LEFT[k]], n_mom[LEFT[k]], n_idx[LEFT[k]],
                       n_son[RIGHT[k]], n_mom[RIGHT[k]], n_idx[RIGHT[k]])) begin
                n_idx[N_DIGITS+k] = n_idx[LEFT[k]];
                n_son[N_DIGITS+k] = n_son[LEFT[k]];
                n_mom[N_DIGITS+k] = n_mom[LEFT[k]];
            end else begin
                n_idx[N_DIGITS+k] = n_idx[RIGHT[k]];
                n_son[N_DIGITS+k] = n_son[RIGHT[k]];
                n_mom[N_DIGITS+k] = n_mom[RIGHT[k]];
            end
        end
        best_idx = n_idx[N_NODES-1];
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            digit        <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= scan_done;
            if (scan_done) begin
                digit <= best_idx;
            end
        end
    end

endmodule

// File: testbench/digit_checker.sv
`timescale 1ns/100ps

module digit_checker #(
    parameter int ADDR_W = 8
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic [ADDR_W-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       prdata,
    input  logic              pslverr,
    input  logic              pready,
    input  logic              check_en,
    input  logic [31:0]       exp_data,
    input  logic              exp_err,
    output int                check_count,
    output int                err_count
);

    // Compare on the edge that completes the access phase
    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            check_count = 0;
            err_count   = 0;
        end else if (psel && penable && check_en) begin
            check_count = check_count + 1;
            if (pready !== 1'b1) begin
                $display("FAIL pready at paddr %h: got %h, expected %h",
                         paddr, pready, 1'b1);
                err_count = err_count + 1;
            end
            if (pslverr !== exp_err) begin
                $display("FAIL pslverr at paddr %h: got %h, expected %h",
                         paddr, pslverr, exp_err);
                err_count = err_count + 1;
            end
            if (!pwrite && (prdata !== exp_data)) begin
                $display("FAIL prdata at paddr %h: got %h, expected %h",
                         paddr, prdata, exp_data);
                err_count = err_count + 1;
            end
        end
    end

endmodule

// File: testbench/digit_classifier_asserts.sv
`timescale 1ns/100ps

module digit_classifier_asserts (
    input logic i_clk,
    input logic i_rst_n,
    input logic pready,
    input logic start,
    input logic busy,
    input logic done,
    input logic result_valid
);

    int fail_count = 0;

    a_pready_high: assert property (@(posedge i_clk) disable iff (!i_rst_n) pready)
        else begin
            fail_count++;
            $error("pready went low");
        end

    a_no_start_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n) !(start && busy))
        else begin
            fail_count++;
            $error("start pulse seen while busy");
        end

    a_busy_done_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n) !(busy && done))
        else begin
            fail_count++;
            $error("busy and done set together");
        end

    a_result_in_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        result_valid |-> busy)
        else begin
            fail_count++;
            $error("result_valid seen while not busy");
        end

endmodule

bind digit_apb_regs digit_classifier_asserts u_asserts (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .pready       (pready),
    .start        (start),
    .busy         (busy),
    .done         (done),
    .result_valid (result_valid)
);

// File: testbench/digit_patterns.hex
// Top hex digit is the expected digit, the other 225 hold the 900-bit image
// Each 15 hex digits hold a pair of 30-bit rows, row 29 first; bit c of a row is column c
0000000000000000003FFFF000FFFFC003FFFF000E001C0038007000E001C0038007000E001C0038007000E001C0038007000E001C0038007000E001C0038007000E001C0038007000E001C0038007000E001C0038007000E001C0038007000FFFFC003FFFF000FFFFC0000000000000000
1000000000000000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000000000000000000
200000000000000003FFFF000FFFFC003FFFF0000001C00000070000001C00000070000001C00000070000001C0000007000FFFFC003FFFF000FFFFC0038000000E00000038000000E00000038000000E00000038000000E00000038000000FFFFC003FFFF000FFFFC0000000000000000
300000000000000003FFFF000FFFFC003FFFF000E00000038000000E00000038000000E00000038000000E00000038000000FFFFC003FFFF000FFFFC0038000000E00000038000000E00000038000000E00000038000000E00000038000000FFFFC003FFFF000FFFFC0000000000000000
4000000000000000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000FFFFC003FFFF000FFFFC0038007000E001C0038007000E001C0038007000E001C0038007000E001C0038007000E001C0038007000E001C0000000000000000
500000000000000003FFFF000FFFFC003FFFF000E00000038000000E00000038000000E00000038000000E00000038000000FFFFC003FFFF000FFFFC00000070000001C00000070000001C00000070000001C00000070000001C0000007000FFFFC003FFFF000FFFFC0000000000000000
600000000000000003FFFF000FFFFC003FFFF000E001C0038007000E001C0038007000E001C0038007000E001C0038007000FFFFC003FFFF000FFFFC00000070000001C00000070000001C00000070000001C00000070000001C0000007000FFFFC003FFFF000FFFFC0000000000000000
7000000000000000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000E00000038000000FFFFC003FFFF000FFFFC0000000000000000
800000000000000003FFFF000FFFFC003FFFF000E001C0038007000E001C0038007000E001C0038007000E001C0038007000FFFFC003FFFF000FFFFC0038007000E001C0038007000E001C0038007000E001C0038007000E001C0038007000FFFFC003FFFF000FFFFC0000000000000000
900000000000000003FFFF000FFFFC003FFFF000E00000038000000E00000038000000E00000038000000E00000038000000FFFFC003FFFF000FFFFC0038007000E001C0038007000E001C0038007000E001C0038007000E001C0038007000FFFFC003FFFF000FFFFC0000000000000000
380000000000000003FFFF000FFFFC003FFFF000E00000038000000E00000038000000E00000038000000E00000038000000FFFFC003FFFF000FFFFC0038000000E00000038000000E00000038000000E00000038000000E00000038000000FFFFC003FFFF000FFFFC0000000000000001
500000000000000003FFFF000FFFFC003FFFF000E00000038000000E00000038000000E00000038000000E00000038000000FFFFC003FFFF000FFFFC00000070000001C00000070000001C00000070000001C00000070000001C0000007000FFFFC003FFFF000FFFFC0000000040000000
0000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000

// File: testbench/tb_digit_classifier.sv
`timescale 1ns/100ps

module tb_digit_classifier
    import digit_pkg::*;
();

    localparam int ADDR_W       = 8;
    localparam int N_VEC        = 13;
    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 8;
    localparam int BUSY_VEC     = 3;
    // Vectors times (40 accesses + 1000 cycles) times the period, doubled
    localparam longint TIMEOUT_NS = longint'(N_VEC) * (40 + 1000) * (2 * CLK_HALF) * 2;

    logic              i_clk;
    logic              i_rst_n;
    logic [ADDR_W-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;

    logic              check_en;
    logic [31:0]       exp_data;
    logic              exp_err;
    int                check_count;
    int                err_count;

    logic [903:0]      patterns [N_VEC];

    digit_classifier_top #(
        .ADDR_W (ADDR_W)
    ) UUT (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    digit_checker #(
        .ADDR_W (ADDR_W)
    ) u_checker (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .prdata      (prdata),
        .pslverr     (pslverr),
        .pready      (pready),
        .check_en    (check_en),
        .exp_data    (exp_data),
        .exp_err     (exp_err),
        .check_count (check_count),
        .err_count   (err_count)
    );

    always #(CLK_HALF) i_clk = ~i_clk;

    function automatic logic [IMG_DIM-1:0] image_row(input int v, input int r);
        return patterns[v][IMG_DIM*r +: IMG_DIM];
    endfunction

    // Setup phase, access phase, then one idle cycle
    task automatic apb_access(input logic [ADDR_W-1:0] addr, input logic wr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge i_clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge i_clk);
        penable = 1'b1;
        @(posedge i_clk);
        rdata = prdata;
        @(negedge i_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_checked(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                                 input logic err);
        logic [31:0] unused_rd;
        check_en = 1'b1;
        exp_data = '0;
        exp_err  = err;
        apb_access(addr, 1'b1, data, unused_rd);
        check_en = 1'b0;
    endtask

    task automatic read_checked(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                                input logic err);
        logic [31:0] rd;
        check_en = 1'b1;
        exp_data = data;
        exp_err  = err;
        apb_access(addr, 1'b0, '0, rd);
        check_en = 1'b0;
    endtask

    task automatic wait_for_done();
        logic [31:0] status;
        status = '0;
        while (!status[1]) begin
            apb_access(ADDR_W'(REG_STATUS), 1'b0, '0, status);
        end
    endtask

    // Upper bits are written as ones and must read back as zero
    task automatic load_image(input int v);
        for (int r = 0; r < IMG_DIM; r++) begin
            write_checked(ADDR_W'(4 * r), {2'b11, image_row(v, r)}, 1'b0);
        end
        for (int r = 0; r < IMG_DIM; r++) begin
            read_checked(ADDR_W'(4 * r), 32'(image_row(v, r)), 1'b0);
        end
    endtask

    task automatic busy_rejects(input int v);
        read_checked(ADDR_W'(REG_STATUS), 32'h1, 1'b0);
        write_checked(ADDR_W'(REG_CTRL), 32'h1, 1'b1);
        write_checked(ADDR_W'(4 * 5), 32'(~image_row(v, 5)), 1'b1);
        read_checked(ADDR_W'(4 * 5), 32'(image_row(v, 5)), 1'b0);
    endtask

    task automatic check_result(input int v);
        read_checked(ADDR_W'(REG_STATUS), 32'h2, 1'b0);
        read_checked(ADDR_W'(REG_RESULT), {28'd0, patterns[v][903:900]}, 1'b0);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the classifier did not finish within the time limit");
        $display("Test failed");
        $finish;
    end

    initial begin
        i_clk    = 1'b0;
        i_rst_n  = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        check_en = 1'b0;
        exp_data = '0;
        exp_err  = 1'b0;
        $readmemh("testbench/digit_patterns.hex", patterns);

        repeat (RESET_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        read_checked(ADDR_W'(REG_STATUS), 32'h0, 1'b0);
        read_checked(ADDR_W'(REG_RESULT), 32'h0, 1'b0);

        // Holes in the map and read-only registers
        read_checked(8'h78, 32'h0, 1'b1);
        read_checked(8'h8C, 32'h0, 1'b1);
        read_checked(8'h02, 32'h0, 1'b1);
        write_checked(8'hFC, 32'h1, 1'b1);
        write_checked(ADDR_W'(REG_STATUS), 32'h3, 1'b1);
        write_checked(ADDR_W'(REG_RESULT), 32'h5, 1'b1);
        read_checked(ADDR_W'(REG_STATUS), 32'h0, 1'b0);
        read_checked(ADDR_W'(REG_RESULT), 32'h0, 1'b0);

        for (int v = 0; v < N_VEC; v++) begin
            load_image(v);
            write_checked(ADDR_W'(REG_CTRL), 32'h1, 1'b0);
            if (v == BUSY_VEC) begin
                busy_rejects(v);
            end
            wait_for_done();
            check_result(v);
            if (v == N_VEC - 1) begin
                write_checked(ADDR_W'(REG_CTRL), 32'h1, 1'b0);
                read_checked(ADDR_W'(REG_STATUS), 32'h1, 1'b0);
                wait_for_done();
                check_result(v);
            end
        end

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, err_count, UUT.u_regs.u_asserts.fail_count);
        if (err_count == 0 && UUT.u_regs.u_asserts.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
